// ==== design/mips_macros.svh ====
// word and address width, register count, reset vector, opcode and funct codes
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath sizes
`define MIPS_WORD_W 32
`define MIPS_REG_N 32

// first fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// primary opcodes, instr[31:26]
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_J 6'h02
`define MIPS_OP_BEQ 6'h04
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_LUI 6'h0F
`define MIPS_OP_LW 6'h23
`define MIPS_OP_SW 6'h2B

// funct codes for r-type, instr[5:0]
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND 6'h24
`define MIPS_FN_OR 6'h25
`define MIPS_FN_SLT 6'h2A

`endif

// ==== design/mips_pkg.sv ====
// package mips_pkg with datapath vector types and the control enums
`default_nettype none

`include "mips_macros.svh"

package mips_pkg;

  // data, addresses and instruction words
  typedef logic [`MIPS_WORD_W-1:0] word_t;

  // register index, 5 bits for 32 registers
  typedef logic [$clog2(`MIPS_REG_N)-1:0] reg_addr_t;

  // raw immediate field of an i-type instruction
  typedef logic [15:0] imm_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  // where the next pc comes from
  typedef enum logic [1:0] {
    pc_seq,
    pc_branch,
    pc_jump
  } pc_src_t;

  // register write-back source
  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_upper
  } wb_src_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_fetch_wait,
    st_decode,
    st_execute,
    st_mem_access,
    st_mem_wait,
    st_writeback
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/mips_regfile.sv ====
// module mips_regfile, three-port register file with r0 fixed at zero and a v0 view
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module mips_regfile (
  input  logic               clk,
  input  logic               reset,
  input  logic               reg_write,
  input  mips_pkg::reg_addr_t ra1,
  input  mips_pkg::reg_addr_t ra2,
  input  mips_pkg::reg_addr_t wa,
  input  mips_pkg::word_t    wd,
  output mips_pkg::word_t    rd1,
  output mips_pkg::word_t    rd2,
  output mips_pkg::word_t    reg_v0
);

  mips_pkg::word_t rf [`MIPS_REG_N];

  // single write port, r0 never takes a value
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_REG_N; i++) begin
        rf[i] <= '0;
      end
    end else if (reg_write && (wa != '0)) begin
      rf[wa] <= wd;
    end
  end

  // two asynchronous read ports
  assign rd1 = (ra1 == '0) ? '0 : rf[ra1];
  assign rd2 = (ra2 == '0) ? '0 : rf[ra2];

  // v0 is register 2, visible for observation
  assign reg_v0 = rf[2];

endmodule

`default_nettype wire

// ==== design/mips_alu.sv ====
// module mips_alu, operand select, arithmetic and logic ops, zero flag, result register
`timescale 1ns/100ps
`default_nettype none

module mips_alu (
  input  logic              clk,
  input  logic              reset,
  input  mips_pkg::alu_op_t alu_op,
  input  logic              alu_src_imm,
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  mips_pkg::word_t   imm_ext,
  output logic              zero,
  output mips_pkg::word_t   alu_out
);

  mips_pkg::word_t b_sel;
  mips_pkg::word_t result;

  // second operand is either rt data or the extended immediate
  assign b_sel = alu_src_imm ? imm_ext : b;

  always_comb begin
    case (alu_op)
      mips_pkg::alu_add: result = a + b_sel;
      mips_pkg::alu_sub: result = a - b_sel;
      mips_pkg::alu_and: result = a & b_sel;
      mips_pkg::alu_or:  result = a | b_sel;
      // signed compare
      mips_pkg::alu_slt: result = {{($bits(result) - 1){1'b0}}, ($signed(a) < $signed(b_sel))};
      default:           result = a + b_sel;
    endcase
  end

  // beq looks at this in the same cycle
  assign zero = (result == '0);

  // holds address and write-back value across the following states
  always_ff @(posedge clk) begin
    if (reset) begin
      alu_out <= '0;
    end else begin
      alu_out <= result;
    end
  end

endmodule

`default_nettype wire

// ==== design/mips_pc_unit.sv ====
// module mips_pc_unit, program counter with reset vector and next-pc selection
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module mips_pc_unit (
  input  logic              clk,
  input  logic              reset,
  input  logic              pc_write,
  input  mips_pkg::pc_src_t pc_src,
  input  mips_pkg::word_t   imm_ext,
  input  logic [25:0]       jump_index,
  output mips_pkg::word_t   pc
);

  mips_pkg::word_t pc_plus4;
  mips_pkg::word_t branch_target;
  mips_pkg::word_t jump_target;
  mips_pkg::word_t pc_next;

  assign pc_plus4 = pc + 32'd4;

  // pc already points past the branch when this is used
  assign branch_target = pc + {imm_ext[29:0], 2'b00};

  // stays inside the current 256 MB region
  assign jump_target = {pc[31:28], jump_index, 2'b00};

  always_comb begin
    case (pc_src)
      mips_pkg::pc_seq:    pc_next = pc_plus4;
      mips_pkg::pc_branch: pc_next = branch_target;
      mips_pkg::pc_jump:   pc_next = jump_target;
      default:             pc_next = pc_plus4;
    endcase
  end

  // execution restarts at the boot vector
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `MIPS_RESET_VECTOR;
    end else if (pc_write) begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/mips_instr_reg.sv ====
// module mips_instr_reg, instruction and memory data registers with field decode
`timescale 1ns/100ps
`default_nettype none

module mips_instr_reg (
  input  logic                clk,
  input  logic                reset,
  input  logic                ir_load,
  input  logic                mdr_load,
  input  mips_pkg::word_t     mem_rdata,
  output logic [5:0]          opcode,
  output logic [5:0]          funct,
  output mips_pkg::reg_addr_t rs,
  output mips_pkg::reg_addr_t rt,
  output mips_pkg::reg_addr_t rd,
  output mips_pkg::word_t     imm_ext,
  output mips_pkg::word_t     imm_upper,
  output mips_pkg::word_t     mdr,
  output logic [25:0]         jump_index
);

  mips_pkg::word_t ir;
  mips_pkg::imm_t  imm;

  // instruction register, loaded in fetch_wait
  always_ff @(posedge clk) begin
    if (reset) begin
      ir <= '0;
    end else if (ir_load) begin
      ir <= mem_rdata;
    end
  end

  // memory data register for lw
  always_ff @(posedge clk) begin
    if (mdr_load) begin
      mdr <= mem_rdata;
    end
  end

  assign opcode     = ir[31:26];
  assign rs         = ir[25:21];
  assign rt         = ir[20:16];
  assign rd         = ir[15:11];
  assign funct      = ir[5:0];
  assign jump_index = ir[25:0];
  assign imm        = ir[15:0];

  assign imm_ext   = {{16{imm[15]}}, imm};
  // lui value with the low half zero
  assign imm_upper = {imm, 16'h0000};

endmodule

`default_nettype wire

// ==== design/mips_control.sv ====
// module mips_control, multicycle FSM and instruction decoder
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module mips_control (
  input  logic              clk,
  input  logic              reset,
  input  logic [5:0]        opcode,
  input  logic [5:0]        funct,
  input  logic              zero,
  output logic              ir_load,
  output logic              mdr_load,
  output logic              pc_write,
  output logic              reg_write,
  output logic              alu_src_imm,
  output logic              reg_dst_rd,
  output logic              mem_read,
  output logic              mem_write,
  output mips_pkg::alu_op_t alu_op,
  output mips_pkg::pc_src_t pc_src,
  output mips_pkg::wb_src_t wb_src
);

  mips_pkg::ctrl_state_t state;
  mips_pkg::ctrl_state_t state_next;

  logic              is_rtype;
  logic              is_lw;
  logic              is_sw;
  logic              is_lui;
  logic              is_beq;
  logic              is_j;
  logic              dec_valid;
  logic              dec_imm;
  mips_pkg::alu_op_t dec_alu_op;

  assign is_rtype = (opcode == `MIPS_OP_RTYPE);
  assign is_lw    = (opcode == `MIPS_OP_LW);
  assign is_sw    = (opcode == `MIPS_OP_SW);
  assign is_lui   = (opcode == `MIPS_OP_LUI);
  assign is_beq   = (opcode == `MIPS_OP_BEQ);
  assign is_j     = (opcode == `MIPS_OP_J);

  // instruction decoder, alu operation and operand choice
  always_comb begin
    dec_valid  = 1'b1;
    dec_imm    = 1'b0;
    dec_alu_op = mips_pkg::alu_add;
    case (opcode)
      `MIPS_OP_RTYPE: begin
        case (funct)
          `MIPS_FN_ADDU: dec_alu_op = mips_pkg::alu_add;
          `MIPS_FN_SUBU: dec_alu_op = mips_pkg::alu_sub;
          `MIPS_FN_AND:  dec_alu_op = mips_pkg::alu_and;
          `MIPS_FN_OR:   dec_alu_op = mips_pkg::alu_or;
          `MIPS_FN_SLT:  dec_alu_op = mips_pkg::alu_slt;
          default:       dec_valid  = 1'b0;
        endcase
      end
      `MIPS_OP_ADDIU, `MIPS_OP_LW, `MIPS_OP_SW, `MIPS_OP_LUI: dec_imm = 1'b1;
      `MIPS_OP_BEQ: dec_alu_op = mips_pkg::alu_sub;
      `MIPS_OP_J:   dec_valid  = 1'b1;
      default:      dec_valid  = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mips_pkg::st_fetch;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    case (state)
      mips_pkg::st_fetch:      state_next = mips_pkg::st_fetch_wait;
      mips_pkg::st_fetch_wait: state_next = mips_pkg::st_decode;
      // unsupported encodings are dropped here
      mips_pkg::st_decode: begin
        state_next = dec_valid ? mips_pkg::st_execute : mips_pkg::st_fetch;
      end
      mips_pkg::st_execute: begin
        if (is_beq || is_j) begin
          state_next = mips_pkg::st_fetch;
        end else if (is_lw || is_sw) begin
          state_next = mips_pkg::st_mem_access;
        end else begin
          state_next = mips_pkg::st_writeback;
        end
      end
      mips_pkg::st_mem_access: begin
        state_next = is_lw ? mips_pkg::st_mem_wait : mips_pkg::st_fetch;
      end
      mips_pkg::st_mem_wait:   state_next = mips_pkg::st_writeback;
      default:                 state_next = mips_pkg::st_fetch;
    endcase
  end

  // strobes and selects per state
  always_comb begin
    ir_load     = 1'b0;
    mdr_load    = 1'b0;
    pc_write    = 1'b0;
    reg_write   = 1'b0;
    alu_src_imm = 1'b0;
    reg_dst_rd  = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    alu_op      = mips_pkg::alu_add;
    pc_src      = mips_pkg::pc_seq;
    wb_src      = mips_pkg::wb_alu;
    case (state)
      // no fetch request while held in reset
      mips_pkg::st_fetch: mem_read = ~reset;
      mips_pkg::st_fetch_wait: begin
        ir_load  = 1'b1;
        pc_write = 1'b1;
      end
      mips_pkg::st_execute: begin
        alu_op      = dec_alu_op;
        alu_src_imm = dec_imm;
        if (is_beq) begin
          pc_write = zero;
          pc_src   = mips_pkg::pc_branch;
        end else if (is_j) begin
          pc_write = 1'b1;
          pc_src   = mips_pkg::pc_jump;
        end
      end
      // address recomputed with the same operands, also selects alu_out as address
      mips_pkg::st_mem_access: begin
        alu_src_imm = 1'b1;
        mem_read    = is_lw;
        mem_write   = is_sw;
      end
      mips_pkg::st_mem_wait: mdr_load = 1'b1;
      mips_pkg::st_writeback: begin
        reg_write  = 1'b1;
        reg_dst_rd = is_rtype;
        if (is_lw) begin
          wb_src = mips_pkg::wb_mem;
        end else if (is_lui) begin
          wb_src = mips_pkg::wb_upper;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/mips_core.sv ====
// module mips_core, top level wiring of control, register file, alu, pc and instruction register
`timescale 1ns/100ps
`default_nettype none

module mips_core (
  input  logic            clk,
  input  logic            reset,
  input  mips_pkg::word_t mem_rdata,
  output mips_pkg::word_t mem_addr,
  output mips_pkg::word_t mem_wdata,
  output logic            mem_read,
  output logic            mem_write,
  output mips_pkg::word_t reg_v0
);

  logic ir_load;
  logic mdr_load;
  logic pc_write;
  logic reg_write;
  logic alu_src_imm;
  logic reg_dst_rd;
  logic zero;
  logic [5:0] opcode;
  logic [5:0] funct;
  logic [25:0] jump_index;

  mips_pkg::alu_op_t   alu_op;
  mips_pkg::pc_src_t   pc_src;
  mips_pkg::wb_src_t   wb_src;
  mips_pkg::reg_addr_t rs;
  mips_pkg::reg_addr_t rt;
  mips_pkg::reg_addr_t rd;
  mips_pkg::word_t     rs_data;
  mips_pkg::word_t     rt_data;
  mips_pkg::word_t     imm_ext;
  mips_pkg::word_t     imm_upper;
  mips_pkg::word_t     mdr;
  mips_pkg::word_t     alu_out;
  mips_pkg::word_t     pc;

  // data accesses keep the immediate operand selected, fetches never do
  assign mem_addr  = alu_src_imm ? alu_out : pc;
  assign mem_wdata = rt_data;

  mips_control u_control (
    .clk(clk), .reset(reset), .opcode(opcode), .funct(funct), .zero(zero),
    .ir_load(ir_load), .mdr_load(mdr_load), .pc_write(pc_write),
    .reg_write(reg_write), .alu_src_imm(alu_src_imm), .reg_dst_rd(reg_dst_rd),
    .mem_read(mem_read), .mem_write(mem_write),
    .alu_op(alu_op), .pc_src(pc_src), .wb_src(wb_src)
  );

  mips_regfile u_regfile (
    .clk(clk), .reset(reset), .reg_write(reg_write),
    .ra1(rs), .ra2(rt),
    .wa(reg_dst_rd ? rd : rt),
    .wd((wb_src == mips_pkg::wb_mem) ? mdr :
        (wb_src == mips_pkg::wb_upper) ? imm_upper : alu_out),
    .rd1(rs_data), .rd2(rt_data), .reg_v0(reg_v0)
  );

  mips_alu u_alu (
    .clk(clk), .reset(reset), .alu_op(alu_op), .alu_src_imm(alu_src_imm),
    .a(rs_data), .b(rt_data), .imm_ext(imm_ext),
    .zero(zero), .alu_out(alu_out)
  );

  mips_pc_unit u_pc_unit (
    .clk(clk), .reset(reset), .pc_write(pc_write), .pc_src(pc_src),
    .imm_ext(imm_ext), .jump_index(jump_index), .pc(pc)
  );

  mips_instr_reg u_instr_reg (
    .clk(clk), .reset(reset), .ir_load(ir_load), .mdr_load(mdr_load),
    .mem_rdata(mem_rdata), .opcode(opcode), .funct(funct),
    .rs(rs), .rt(rt), .rd(rd), .imm_ext(imm_ext), .imm_upper(imm_upper),
    .mdr(mdr), .jump_index(jump_index)
  );

endmodule

`default_nettype wire

// ==== bench/mips_core_checker.sv ====
// module mips_core_checker with memory strobe assertions, and its bind into mips_core
`timescale 1ns/100ps
`default_nettype none

module mips_core_checker (
  input logic            clk,
  input logic            reset,
  input logic            mem_read,
  input logic            mem_write,
  input mips_pkg::word_t mem_addr
);

  // number of failed assertions
  int failures = 0;

  // one shared memory port, one access per cycle
  a_one_strobe: assert property (@(posedge clk) !(mem_read && mem_write))
    else begin
      failures++;
      $error("mem_read and mem_write high in the same cycle");
    end

  // word accesses only
  a_aligned: assert property (@(posedge clk) (mem_read || mem_write) |-> (mem_addr[1:0] == 2'b00))
    else begin
      failures++;
      $error("strobed address %h is not word aligned", mem_addr);
    end

  a_reset_quiet: assert property (@(posedge clk) reset |-> !(mem_read || mem_write))
    else begin
      failures++;
      $error("memory strobe high while reset is asserted");
    end

endmodule

bind mips_core mips_core_checker u_checker (
  .clk(clk),
  .reset(reset),
  .mem_read(mem_read),
  .mem_write(mem_write),
  .mem_addr(mem_addr)
);

`default_nettype wire

// ==== bench/mips_core_tb.sv ====
// module mips_core_tb, clock, reset, memory model, input file loading, checks and report
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module mips_core_tb;

  localparam int MEM_WORDS = 64;
  localparam int RESET_CYCLES = 10;
  localparam int FIRST_READ_TIMEOUT = 20;
  localparam int HALT_TIMEOUT = 2000;

  logic            clk;
  logic            reset;
  mips_pkg::word_t mem_rdata;
  mips_pkg::word_t mem_addr;
  mips_pkg::word_t mem_wdata;
  logic            mem_read;
  logic            mem_write;
  mips_pkg::word_t reg_v0;

  // code at the reset vector, data at the bottom of the address space
  mips_pkg::word_t code_mem [MEM_WORDS];
  mips_pkg::word_t data_mem [MEM_WORDS];

  mips_pkg::word_t v0_expected [$];
  mips_pkg::word_t mem_exp_addr [$];
  mips_pkg::word_t mem_exp_data [$];
  mips_pkg::word_t halt_addr;

  mips_pkg::word_t v0_seen [$];
  mips_pkg::word_t v0_last;
  logic            recording;

  // strobes sampled mid-cycle, served just after the next rising edge
  logic            req_read;
  logic            req_write;
  mips_pkg::word_t req_addr;
  mips_pkg::word_t req_wdata;

  int errors;
  int checks;

  mips_core u_mips_core (
    .clk(clk), .reset(reset), .mem_rdata(mem_rdata),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_read(mem_read), .mem_write(mem_write), .reg_v0(reg_v0)
  );

  always #50 clk = ~clk;

  task automatic compare_value(input string name, input mips_pkg::word_t observed,
                               input mips_pkg::word_t expected);
    checks++;
    if (observed !== expected) begin
      errors++;
      $display("FAIL %s observed %h expected %h at %0t", name, observed, expected, $time);
    end
  endtask

  function automatic logic in_code(input mips_pkg::word_t addr);
    return (addr >> 8) == (`MIPS_RESET_VECTOR >> 8);
  endfunction

  function automatic logic in_data(input mips_pkg::word_t addr);
    return (addr >> 8) == 0;
  endfunction

  function automatic mips_pkg::word_t read_word(input mips_pkg::word_t addr);
    if (in_code(addr)) begin
      return code_mem[addr[7:2]];
    end else if (in_data(addr)) begin
      return data_mem[addr[7:2]];
    end
    return 'x;
  endfunction

  // one tag letter per line, then one or two hex numbers
  task automatic load_input();
    int fd;
    int n;
    string line;
    byte tag;
    mips_pkg::word_t a;
    mips_pkg::word_t b;
    fd = $fopen("bench/mips_core_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open bench/mips_core_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 2) begin
          tag = line.getc(0);
          a = '0;
          b = '0;
          n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, b);
          case (tag)
            "P": code_mem[a[7:2]] = b;
            "D": data_mem[a[7:2]] = b;
            "V": v0_expected.push_back(a);
            "M": begin
              mem_exp_addr.push_back(a);
              mem_exp_data.push_back(b);
            end
            "H": halt_addr = a;
            "#": ;
            default: begin
              errors++;
              $display("unknown line in the input file: %s", line);
            end
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  always @(negedge clk) begin
    req_read  = mem_read;
    req_write = mem_write;
    req_addr  = mem_addr;
    req_wdata = mem_wdata;
  end

  // read data shows up in the cycle after the strobe
  always @(posedge clk) begin
    #1;
    if (req_write) begin
      if (in_data(req_addr)) begin
        data_mem[req_addr[7:2]] = req_wdata;
      end else begin
        errors++;
        $display("store outside the data region at address %h", req_addr);
      end
    end
    if (req_read) begin
      if (!in_code(req_addr) && !in_data(req_addr)) begin
        errors++;
        $display("read outside the code and data regions at address %h", req_addr);
      end
      mem_rdata = read_word(req_addr);
    end
  end

  always @(negedge clk) begin
    if (reset) begin
      compare_value("mem_read", mem_read, 1'b0);
      compare_value("mem_write", mem_write, 1'b0);
    end
  end

  // every change of v0 after reset goes into the trace
  always @(negedge clk) begin
    if (recording && (reg_v0 !== v0_last)) begin
      v0_seen.push_back(reg_v0);
      v0_last = reg_v0;
    end
  end

  initial begin
    int i;
    int n;
    logic seen;
    int assert_fails;
    clk       = 1'b0;
    reset     = 1'b1;
    mem_rdata = '0;
    recording = 1'b0;
    v0_last   = '0;
    req_read  = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    halt_addr = '0;
    errors    = 0;
    checks    = 0;
    for (i = 0; i < MEM_WORDS; i++) begin
      code_mem[i] = '0;
      data_mem[i] = '0;
    end
    load_input();

    for (i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
    end
    #1;
    reset     = 1'b0;
    recording = 1'b1;
    v0_last   = reg_v0;

    seen = 1'b0;
    for (n = 0; n < FIRST_READ_TIMEOUT && !seen; n++) begin
      @(negedge clk);
      if (mem_read || mem_write) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      compare_value("mem_read", mem_read, 1'b1);
      compare_value("mem_addr", mem_addr, `MIPS_RESET_VECTOR);
    end else begin
      errors++;
      $display("timeout waiting for the first memory read after reset");
    end

    // the program ends in a jump to itself
    seen = 1'b0;
    for (n = 0; n < HALT_TIMEOUT && !seen; n++) begin
      @(negedge clk);
      if (mem_read && (mem_addr == halt_addr)) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      errors++;
      $display("timeout waiting for the fetch at halt address %h", halt_addr);
    end
    recording = 1'b0;

    compare_value("reg_v0 change count", v0_seen.size(), v0_expected.size());
    for (i = 0; i < v0_expected.size() && i < v0_seen.size(); i++) begin
      compare_value($sformatf("reg_v0 change %0d", i), v0_seen[i], v0_expected[i]);
    end
    for (i = 0; i < mem_exp_addr.size(); i++) begin
      compare_value($sformatf("mem[%h]", mem_exp_addr[i]), read_word(mem_exp_addr[i]),
                    mem_exp_data[i]);
    end

    // failed strobe assertions in the bound checker
    assert_fails = u_mips_core.u_checker.failures;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
    if ((errors == 0) && (assert_fails == 0)) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/mips_core_input.txt ====
# P: address, instruction word   D: address, initial data word   H: halt address
# V: expected reg_v0 values in order of change   M: address, expected final data word
P bfc00000 24021234 # addiu v0, zero, 0x1234
P bfc00004 3c03abcd # lui r3, 0xabcd
P bfc00008 240400ff # addiu r4, zero, 0xff
P bfc0000c 00641021 # addu v0, r3, r4
P bfc00010 00441023 # subu v0, v0, r4
P bfc00014 00441025 # or v0, v0, r4
P bfc00018 00641024 # and v0, r3, r4
P bfc0001c 0064102a # slt v0, r3, r4 (signed, gives 1)
P bfc00020 0083102a # slt v0, r4, r3
P bfc00024 8c050040 # lw r5, 0x40(zero)
P bfc00028 00a01021 # addu v0, r5, zero
P bfc0002c 8c060044 # lw r6, 0x44(zero)
P bfc00030 00a63821 # addu r7, r5, r6
P bfc00034 ac070048 # sw r7, 0x48(zero)
P bfc00038 8c020048 # lw v0, 0x48(zero)
P bfc0003c ac03004c # sw r3, 0x4c(zero)
P bfc00040 10a60001 # beq r5, r6, +1 not taken
P bfc00044 24020055 # addiu v0, zero, 0x55
P bfc00048 10a50001 # beq r5, r5, +1 taken
P bfc0004c 24020bad # skipped by the branch
P bfc00050 0bf00016 # j bfc00058
P bfc00054 24020bee # skipped by the jump
P bfc00058 24020066 # addiu v0, zero, 0x66
P bfc0005c 24007777 # addiu zero, zero, 0x7777
P bfc00060 00001021 # addu v0, zero, zero
P bfc00064 ac020050 # sw v0, 0x50(zero)
P bfc00068 0bf0001a # j bfc00068, halt
D 00000040 13572468
D 00000044 11111111
D 00000050 ffffffff
V 00001234
V abcd00ff
V abcd0000
V abcd00ff
V 00000000
V 00000001
V 00000000
V 13572468
V 24683579
V 00000055
V 00000066
V 00000000
M 00000040 13572468
M 00000048 24683579
M 0000004c abcd0000
M 00000050 00000000
H bfc00068

// ==== sim.f ====
+incdir+design
design/mips_pkg.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_pc_unit.sv
design/mips_instr_reg.sv
design/mips_control.sv
design/mips_core.sv
bench/mips_core_checker.sv
bench/mips_core_tb.sv

// ==== Bender.yml ====
package:
  name: mips_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mips_pkg.sv
      - design/mips_regfile.sv
      - design/mips_alu.sv
      - design/mips_pc_unit.sv
      - design/mips_instr_reg.sv
      - design/mips_control.sv
      - design/mips_core.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/mips_core_checker.sv
      - bench/mips_core_tb.sv
